// File: dynode_readout.f
+incdir+common
common/dynode_pkg.sv
src/event_capture.sv
src/sample_delay_line.sv
readout/trigger_frame_builder.sv
readout/trigger_fifo.sv
src/link_word_aligner.sv
src/dynode_readout_top.sv
verif/tb_dynode_readout.sv

// File: Makefile
SRCS := $(shell grep -v '^+' dynode_readout.f) common/dynode_consts.svh
BIN  := obj_dir/Vtb_dynode_readout

.PHONY: all run clean

all: $(BIN)

$(BIN): dynode_readout.f $(SRCS)
	verilator --binary --assert -j 0 -Wno-fatal --top-module tb_dynode_readout \
		-f dynode_readout.f -Mdir obj_dir -o Vtb_dynode_readout

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

// File: verif/tb_dynode_readout.sv
/*
 * dynode readout testbench
 * drives events, sample ramps and a trigger link model into the readout top,
 * checks trigger bytes, framed FIFO records and link word alignment
 */
`timescale 1ns/1ns
`include "dynode_consts.svh"

module tb_dynode_readout
   import dynode_pkg::*;
();

   localparam int TIMEOUT_CYC = 200;             // cycles allowed per wait loop

   logic                clk = 1'b0;
   logic                rst;
   event_in_t           evt;
   raw_t                raw_sample;
   sample_t             blcor_sample;
   logic                trigger;
   readout_mode_t       data_mode;
   logic [1:0]          channel_select;
   logic [`DLY_W-1:0]   data_delay_len;
   logic                fifo_ren;
   link_word_t          link_word;
   logic [`TRIG_W-1:0]  mcu_trigger;
   logic [`WHOLE_W-1:0] event_whole;
   logic [`FRAC_W-1:0]  event_frac;
   fifo_word_t          fifo_rdata;
   logic                fifo_not_empty;
   logic                fifo_nearly_full;
   logic                bitslip;
   logic                link_aligned;
   logic [15:0]         bitslip_count;

   logic [11:0] ramp = '0;                       // shared sample ramp
   int          slips_seen = 0;                  // slips applied by the link model
   int          link_offset;                     // extra rotation to break framing
   int          seed = 32'h50d0_4641;

   always #2 clk = ~clk;                         // 4 ns period

   dynode_readout_top i_dynode_readout_top (
      .clk              (clk),
      .rst              (rst),
      .evt              (evt),
      .raw_sample       (raw_sample),
      .blcor_sample     (blcor_sample),
      .trigger          (trigger),
      .data_mode        (data_mode),
      .channel_select   (channel_select),
      .data_delay_len   (data_delay_len),
      .fifo_ren         (fifo_ren),
      .link_word        (link_word),
      .mcu_trigger      (mcu_trigger),
      .event_whole      (event_whole),
      .event_frac       (event_frac),
      .fifo_rdata       (fifo_rdata),
      .fifo_not_empty   (fifo_not_empty),
      .fifo_nearly_full (fifo_nearly_full),
      .bitslip          (bitslip),
      .link_aligned     (link_aligned),
      .bitslip_count    (bitslip_count)
   );

   function automatic logic [3:0] rotate_pattern(input logic [3:0] p, input int n);
      logic [3:0] r;
      r = p;
      for (int i = 0; i < n % 4; i++)
         r = {r[2:0], r[3]};                     // one bit per slip
      return r;
   endfunction

   assign raw_sample   = ramp[`RAW_W-1:0];
   assign blcor_sample = ramp;
   assign link_word    = rotate_pattern(4'b0001, slips_seen + link_offset);

   always @(posedge clk) begin
      #1;
      ramp <= ramp + 12'd1;                      // wraps at 12 bits
   end

   // link model shifts the word on each bitslip seen at the edge
   always @(posedge clk) begin
      if (bitslip) begin
         #1;
         slips_seen <= slips_seen + 1;
      end
   end

   function automatic logic [7:0] expected_trig_byte(input logic strobe, input evtime_t t);
      if (!strobe)
         return 8'hFF;                           // idle byte
      if (t[11:6] == 6'h3F)
         return 8'hF8;                           // saturated
      return t[11:4];
   endfunction

   function automatic fifo_word_t frame_nwords(input readout_mode_t m);
      case (m)
         MODE_ENERGY:      return 16'd1;
         MODE_BLCOR_SHORT: return 16'd17;
         default:          return 16'd33;        // raw and corrected
      endcase
   endfunction

   function automatic fifo_word_t onehot_mask(input logic [1:0] ch);
      case (ch)
         2'd0:    return 16'h0001;
         2'd1:    return 16'h0002;
         2'd2:    return 16'h0004;
         default: return 16'h0008;
      endcase
   endfunction

   function automatic fifo_word_t sample_mask(input readout_mode_t m);
      return (m == MODE_RAW) ? 16'h00FF : 16'h0FFF;   // raw is zero extended
   endfunction

   task automatic stop_with_error(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_value(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
      if (actual !== expected)
         stop_with_error($sformatf("Fail %s expected %h actual %h", name, expected, actual));
   endtask

   task automatic pop_word(input string name, output fifo_word_t w);
      int waited;
      waited = 0;
      while (!fifo_not_empty) begin
         @(posedge clk);
         #1;
         waited++;
         if (waited > TIMEOUT_CYC)
            stop_with_error({"timeout waiting for FIFO data in ", name});
      end
      w        = fifo_rdata;                     // fall-through head word
      fifo_ren = 1'b1;
      @(posedge clk);
      #1;
      fifo_ren = 1'b0;
   endtask

   task automatic wait_link(input logic level, input string what);
      int waited;
      waited = 0;
      while (link_aligned !== level) begin
         @(posedge clk);
         #1;
         waited++;
         if (waited > TIMEOUT_CYC)
            stop_with_error({"timeout waiting for link ", what});
      end
   endtask

   // one cycle energy load, or a bare trigger pulse
   task automatic request_frame(input logic with_energy, input energy_t e);
      evt.energy   = e;
      evt.ene_load = with_energy;
      trigger      = ~with_energy;
      @(posedge clk);
      #1;
      evt.ene_load = 1'b0;
      trigger      = 1'b0;
   endtask

   task automatic check_frame(input string name, input readout_mode_t m,
                              input logic [1:0] ch, input energy_t e);
      fifo_word_t w;
      fifo_word_t prev;
      fifo_word_t n;
      n = frame_nwords(m);
      pop_word(name, w);
      check_value({name, " preamble"}, `FRAME_PREAMBLE, w);
      pop_word(name, w);
      check_value({name, " nwords"}, n, w);
      pop_word(name, w);
      check_value({name, " mask"}, onehot_mask(ch), w);
      prev = '0;
      for (int k = 1; k < int'(n); k++) begin
         pop_word(name, w);
         if (k == 1)
            check_value({name, " first sample range"}, 16'h0, w & ~sample_mask(m));
         else
            check_value($sformatf("%s sample %0d", name, k),
                        (prev + 16'd1) & sample_mask(m), w);
         prev = w;
      end
      pop_word(name, w);
      check_value({name, " energy"}, 16'(e), w);   // energy closes the frame
   endtask

   initial begin
      readout_mode_t modes [3];
      logic [3:0]    delays [3];
      energy_t       last_energy;
      evtime_t       t;
      logic          strobe;

      modes          = '{MODE_RAW, MODE_BLCOR, MODE_BLCOR_SHORT};
      delays         = '{4'd0, 4'd7, 4'd15};
      rst            = 1'b1;
      evt            = '0;
      trigger        = 1'b0;
      data_mode      = MODE_ENERGY;
      channel_select = 2'd0;
      data_delay_len = '0;
      fifo_ren       = 1'b0;
      link_offset    = 0;
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;

      // pattern 0001 needs three slips to reach bit 3
      wait_link(1'b1, "initial alignment");
      check_value("link slips", 16'd3, bitslip_count);

      for (int i = 0; i < 40; i++) begin
         t = evtime_t'($random(seed));
         if (i % 4 == 0)
            t[11:6] = '1;                        // force saturated fraction
         strobe         = (i % 5 != 3);          // some idle cycles
         evt.evt_strobe = strobe;
         evt.evt_time   = t;
         @(posedge clk);
         #1;
         check_value($sformatf("trig byte %0d", i), 16'(expected_trig_byte(strobe, t)),
                     16'(mcu_trigger));
         if (strobe) begin
            check_value($sformatf("whole %0d", i), 16'(t[19:12]), 16'(event_whole));
            check_value($sformatf("frac %0d", i), 16'(t[11:0]), 16'(event_frac));
         end
      end
      evt.evt_strobe = 1'b0;

      data_mode = MODE_ENERGY;
      for (int ch = 0; ch < 4; ch++) begin
         channel_select = 2'(ch);
         last_energy    = energy_t'($random(seed));
         request_frame(1'b1, last_energy);
         check_frame($sformatf("energy ch%0d", ch), MODE_ENERGY, 2'(ch), last_energy);
      end

      channel_select = 2'd1;
      foreach (modes[m]) begin
         foreach (delays[d]) begin
            data_mode      = modes[m];
            data_delay_len = delays[d];
            repeat (48) @(posedge clk);          // refill all delay taps
            #1;
            last_energy = energy_t'($random(seed));
            request_frame(1'b1, last_energy);
            check_frame($sformatf("mode %0d dly %0d", modes[m], delays[d]), modes[m],
                        2'd1, last_energy);
         end
      end

      // bare trigger with junk on the energy bus that must not load
      channel_select = 2'd3;
      request_frame(1'b0, ~last_energy);
      check_frame("trigger only", MODE_BLCOR_SHORT, 2'd3, last_energy);

      // fill to 56 words without reading
      data_mode = MODE_BLCOR;
      request_frame(1'b1, last_energy);
      repeat (40) @(posedge clk);                // 36 words written back to back
      #1;
      data_mode = MODE_ENERGY;
      for (int f = 0; f < 5; f++) begin
         check_value($sformatf("nearly full at %0d", 36 + 4 * f), 16'd0,
                     16'(fifo_nearly_full));
         request_frame(1'b1, last_energy);
         repeat (8) @(posedge clk);              // 4 word frame
         #1;
      end
      check_value("nearly full at 56", 16'd1, 16'(fifo_nearly_full));
      check_frame("fill long", MODE_BLCOR, 2'd3, last_energy);
      for (int f = 0; f < 5; f++)
         check_frame($sformatf("fill energy %0d", f), MODE_ENERGY, 2'd3, last_energy);
      check_value("nearly full drained", 16'd0, 16'(fifo_nearly_full));

      link_offset = 3;                           // word becomes 0100
      wait_link(1'b0, "alignment loss");
      wait_link(1'b1, "realignment");
      check_value("link slips after loss", 16'd4, bitslip_count);

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// File: src/dynode_readout_top.sv
/*
 * dynode readout top
 * event trigger encoding, sample delay, frame building into the trigger
 * data FIFO and trigger link word alignment for one dynode channel
 */
`timescale 1ns/1ns
`include "dynode_consts.svh"

module dynode_readout_top
   import dynode_pkg::*;
(
   input  logic                clk,
   input  logic                rst,
   input  event_in_t           evt,              // from upstream pulse processing
   input  raw_t                raw_sample,
   input  sample_t             blcor_sample,
   input  logic                trigger,
   input  readout_mode_t       data_mode,
   input  logic [1:0]          channel_select,
   input  logic [`DLY_W-1:0]   data_delay_len,
   input  logic                fifo_ren,
   input  link_word_t          link_word,
   output logic [`TRIG_W-1:0]  mcu_trigger,
   output logic [`WHOLE_W-1:0] event_whole,
   output logic [`FRAC_W-1:0]  event_frac,
   output fifo_word_t          fifo_rdata,
   output logic                fifo_not_empty,
   output logic                fifo_nearly_full,
   output logic                bitslip,
   output logic                link_aligned,
   output logic [15:0]         bitslip_count
);

   logic       frame_load;
   energy_t    latched_energy;
   sample_t    delayed_sample;
   fifo_word_t fifo_wdata;
   logic       fifo_wen;

   event_capture i_event_capture (
      .clk            (clk),
      .rst            (rst),
      .evt            (evt),
      .trigger        (trigger),
      .mcu_trigger    (mcu_trigger),
      .event_whole    (event_whole),
      .event_frac     (event_frac),
      .frame_load     (frame_load),
      .latched_energy (latched_energy)
   );

   sample_delay_line i_sample_delay_line (
      .clk            (clk),
      .raw_sample     (raw_sample),
      .blcor_sample   (blcor_sample),
      .data_mode      (data_mode),
      .data_delay_len (data_delay_len),
      .delayed_sample (delayed_sample)
   );

   trigger_frame_builder i_trigger_frame_builder (
      .clk            (clk),
      .rst            (rst),
      .frame_load     (frame_load),
      .data_mode      (data_mode),
      .channel_select (channel_select),
      .delayed_sample (delayed_sample),
      .latched_energy (latched_energy),
      .fifo_wdata     (fifo_wdata),
      .fifo_wen       (fifo_wen)
   );

   trigger_fifo i_trigger_fifo (
      .clk              (clk),
      .rst              (rst),
      .fifo_wdata       (fifo_wdata),
      .fifo_wen         (fifo_wen),
      .fifo_ren         (fifo_ren),
      .fifo_rdata       (fifo_rdata),
      .fifo_not_empty   (fifo_not_empty),
      .fifo_nearly_full (fifo_nearly_full)
   );

   link_word_aligner i_link_word_aligner (
      .clk           (clk),
      .rst           (rst),
      .link_word     (link_word),
      .bitslip       (bitslip),
      .link_aligned  (link_aligned),
      .bitslip_count (bitslip_count)
   );

endmodule

// File: src/link_word_aligner.sv
/*
 * trigger link word aligner
 * waits for the link to settle, then slips one bit at a time until the
 * word marker in bit 3 is seen; restarts if the marker is lost
 */
`timescale 1ns/1ns
`include "dynode_consts.svh"

module link_word_aligner
   import dynode_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  link_word_t  link_word,
   output logic        bitslip,
   output logic        link_aligned,
   output logic [15:0] bitslip_count
);

   align_state_t state;
   logic [3:0]   cyc_cnt;                        // settle and wait timer
   logic         marker;

   assign marker = link_word[3];

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= AL_SETTLE;
         cyc_cnt <= '0;
      end else begin
         case (state)
            AL_SETTLE: begin
               cyc_cnt <= cyc_cnt + 4'd1;
               if (cyc_cnt == 4'(`ALIGN_SETTLE-1)) begin
                  cyc_cnt <= '0;
                  state   <= AL_CHECK;
               end
            end
            AL_CHECK:
               state <= marker ? AL_HALT : AL_SLIP;
            AL_SLIP: begin
               cyc_cnt <= '0;
               state   <= AL_WAIT;
            end
            AL_WAIT: begin
               cyc_cnt <= cyc_cnt + 4'd1;
               if (cyc_cnt == 4'(`ALIGN_WAIT-1)) begin
                  cyc_cnt <= '0;
                  state   <= AL_CHECK;           // slip has reached the word
               end
            end
            AL_HALT: begin
               cyc_cnt <= '0;
               if (!marker)
                  state <= AL_SETTLE;            // lost framing, start over
            end
            default: begin
               cyc_cnt <= '0;
               state   <= AL_SETTLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         bitslip       <= 1'b0;
         link_aligned  <= 1'b0;
         bitslip_count <= '0;
      end else begin
         bitslip      <= (state == AL_SLIP);     // one cycle per slip state
         link_aligned <= (state == AL_HALT);
         if (bitslip)
            bitslip_count <= bitslip_count + 16'd1;
      end
   end

   a_bitslip_single: assert property (@(posedge clk) disable iff (rst)
      bitslip |=> !bitslip)
      else $error("bitslip held for two cycles");

endmodule

// File: readout/trigger_fifo.sv
/*
 * trigger data FIFO
 * first-word fall-through synchronous FIFO with not-empty and nearly-full
 * flags, no back-pressure toward the frame builder
 */
`timescale 1ns/1ns
`include "dynode_consts.svh"

module trigger_fifo
   import dynode_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  fifo_word_t fifo_wdata,
   input  logic       fifo_wen,
   input  logic       fifo_ren,
   output fifo_word_t fifo_rdata,
   output logic       fifo_not_empty,
   output logic       fifo_nearly_full
);

   fifo_word_t           mem [`FIFO_DEPTH];
   logic [`FIFO_AW-1:0]  wr_ptr;
   logic [`FIFO_AW-1:0]  rd_ptr;
   logic [`FIFO_AW:0]    count;                  // one extra bit for full
   logic                 full;
   logic                 do_wr;
   logic                 do_rd;

   assign full             = (count == (`FIFO_AW+1)'(`FIFO_DEPTH));
   assign fifo_not_empty   = (count != '0);
   assign fifo_nearly_full = (count >= (`FIFO_AW+1)'(`FIFO_NEARLY));
   assign do_wr            = fifo_wen & ~full;   // drop on overflow
   assign do_rd            = fifo_ren & fifo_not_empty;
   assign fifo_rdata       = mem[rd_ptr];        // head word shown directly

   always_ff @(posedge clk) begin
      if (do_wr)
         mem[wr_ptr] <= fifo_wdata;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;             // wraps at depth
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   a_no_overflow: assert property (@(posedge clk) disable iff (rst)
      fifo_wen |-> !full)
      else $error("trigger fifo written while full");

   a_no_underflow: assert property (@(posedge clk) disable iff (rst)
      fifo_ren |-> fifo_not_empty)
      else $error("trigger fifo read while empty");

endmodule

// File: readout/trigger_frame_builder.sv
/*
 * trigger frame builder
 * on a frame load writes preamble, word count, channel mask, the delayed
 * samples and the energy into the trigger data FIFO on consecutive cycles
 */
`timescale 1ns/1ns
`include "dynode_consts.svh"

module trigger_frame_builder
   import dynode_pkg::*;
(
   input  logic          clk,
   input  logic          rst,
   input  logic          frame_load,
   input  readout_mode_t data_mode,
   input  logic [1:0]    channel_select,
   input  sample_t       delayed_sample,
   input  energy_t       latched_energy,
   output fifo_word_t    fifo_wdata,
   output logic          fifo_wen
);

   frame_state_t state;
   fifo_word_t   nwords;                         // words after the mask
   fifo_word_t   chan_mask;
   logic [5:0]   words_left;                     // data phase countdown

   always_comb begin
      case (data_mode)
         MODE_ENERGY:      nwords = fifo_word_t'(1);
         MODE_RAW,
         MODE_BLCOR:       nwords = fifo_word_t'(`NWORDS_LONG);
         MODE_BLCOR_SHORT: nwords = fifo_word_t'(`NWORDS_SHORT);
         default:          nwords = fifo_word_t'(1);
      endcase
   end

   assign chan_mask = fifo_word_t'(1) << channel_select;   // one hot

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= FS_IDLE;
         fifo_wen   <= 1'b0;
         words_left <= '0;
      end else begin
         case (state)
            FS_IDLE: begin
               fifo_wen   <= 1'b0;
               words_left <= nwords[5:0];
               if (frame_load)
                  state <= FS_PREAMBLE;          // loads during a frame are dropped
            end
            FS_PREAMBLE: begin
               fifo_wen <= 1'b1;                 // first write, 2 after load
               state    <= FS_NWORDS;
            end
            FS_NWORDS: begin
               fifo_wen <= 1'b1;
               state    <= FS_MASK;
            end
            FS_MASK: begin
               fifo_wen <= 1'b1;
               state    <= FS_DATA;
            end
            FS_DATA: begin
               fifo_wen   <= 1'b1;
               words_left <= words_left - 6'd1;
               if (words_left == 6'd1)
                  state <= FS_IDLE;              // energy is the last word
            end
            default: begin
               fifo_wen <= 1'b0;
               state    <= FS_IDLE;
            end
         endcase
      end
   end

   // write data per state
   always_ff @(posedge clk) begin
      case (state)
         FS_PREAMBLE: fifo_wdata <= `FRAME_PREAMBLE;
         FS_NWORDS:   fifo_wdata <= nwords;
         FS_MASK:     fifo_wdata <= chan_mask;
         FS_DATA: begin
            if (words_left == 6'd1)
               fifo_wdata <= {{(`FIFO_W-`SAMPLE_W){1'b0}}, latched_energy};
            else
               fifo_wdata <= {{(`FIFO_W-`SAMPLE_W){1'b0}}, delayed_sample};
         end
         default:     fifo_wdata <= fifo_wdata;
      endcase
   end

   a_state_legal: assert property (@(posedge clk) disable iff (rst)
      state inside {FS_IDLE, FS_PREAMBLE, FS_NWORDS, FS_MASK, FS_DATA})
      else $error("frame builder in illegal state %0d", state);

endmodule

// File: src/sample_delay_line.sv
/*
 * sample delay line
 * selects raw or corrected samples, aligns corrected data to the event,
 * then applies the pileup tap and a programmable delay of 0 to 15 cycles
 */
`timescale 1ns/1ns
`include "dynode_consts.svh"

module sample_delay_line
   import dynode_pkg::*;
(
   input  logic              clk,
   input  raw_t              raw_sample,
   input  sample_t           blcor_sample,
   input  readout_mode_t     data_mode,
   input  logic [`DLY_W-1:0] data_delay_len,
   output sample_t           delayed_sample
);

   sample_t blcor_q [`BLCOR_ALIGN_DLY];          // fixed alignment taps
   sample_t head_q  [`PILEUP_DLY+1];             // select reg plus pileup taps
   sample_t prog_q  [`MAX_DLY];                  // programmable taps

   always_ff @(posedge clk) begin
      blcor_q[0] <= blcor_sample;
      for (int i = 1; i < `BLCOR_ALIGN_DLY; i++)
         blcor_q[i] <= blcor_q[i-1];
   end

   // source select at the head of the chain
   always_ff @(posedge clk) begin
      if (data_mode == MODE_RAW)
         head_q[0] <= {{(`SAMPLE_W-`RAW_W){1'b0}}, raw_sample};   // zero extend
      else
         head_q[0] <= blcor_q[`BLCOR_ALIGN_DLY-1];
      for (int i = 1; i <= `PILEUP_DLY; i++)
         head_q[i] <= head_q[i-1];
   end

   always_ff @(posedge clk) begin
      prog_q[0] <= head_q[`PILEUP_DLY];
      for (int i = 1; i < `MAX_DLY; i++)
         prog_q[i] <= prog_q[i-1];
      delayed_sample <= prog_q[data_delay_len];  // 6 + len from source
   end

endmodule

// File: src/event_capture.sv
/*
 * event capture
 * encodes the coincidence trigger byte, splits event time into whole and
 * fractional parts, latches corrected energy and issues the frame load pulse
 */
`timescale 1ns/1ns
`include "dynode_consts.svh"

module event_capture
   import dynode_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   input  event_in_t            evt,
   input  logic                 trigger,          // record request w/o energy update
   output logic [`TRIG_W-1:0]   mcu_trigger,
   output logic [`WHOLE_W-1:0]  event_whole,
   output logic [`FRAC_W-1:0]   event_frac,
   output logic                 frame_load,
   output energy_t              latched_energy
);

   logic time_sat;                               // fraction near wrap

   assign time_sat = &evt.evt_time[11:6];

   always_ff @(posedge clk) begin
      if (rst) begin
         mcu_trigger <= `TRIG_IDLE;
         frame_load  <= 1'b0;
      end else begin
         if (!evt.evt_strobe)
            mcu_trigger <= `TRIG_IDLE;           // idle byte on the link
         else if (time_sat)
            mcu_trigger <= `TRIG_SAT;
         else
            mcu_trigger <= evt.evt_time[11:4];   // coarse fraction to mcu
         frame_load <= evt.ene_load | trigger;   // energy load wins, same pulse
      end
   end

   // time split follows every cycle
   always_ff @(posedge clk) begin
      event_whole <= {{(`WHOLE_W-8){1'b0}}, evt.evt_time[19:12]};
      event_frac  <= evt.evt_time[`FRAC_W-1:0];
   end

   always_ff @(posedge clk) begin
      if (evt.ene_load)
         latched_energy <= evt.energy;           // kept for trigger-only frames
   end

endmodule

// File: common/dynode_pkg.sv
/*
 * dynode readout types
 * sample, time, energy and link words, mode and state encodings,
 * and the event bundle from upstream pulse processing
 */
`include "dynode_consts.svh"

package dynode_pkg;

   typedef logic [`SAMPLE_W-1:0] sample_t;     // baseline corrected sample
   typedef logic [`RAW_W-1:0]    raw_t;        // raw adc code
   typedef logic [`TIME_W-1:0]   evtime_t;     // event time, whole and fraction
   typedef logic [`SAMPLE_W-1:0] energy_t;     // pileup corrected energy
   typedef logic [`FIFO_W-1:0]   fifo_word_t;
   typedef logic [`LINK_W-1:0]   link_word_t;

   typedef enum logic [1:0] {
      MODE_ENERGY      = 2'd0,   // energy word only
      MODE_RAW         = 2'd1,   // raw adc samples
      MODE_BLCOR       = 2'd2,   // corrected samples, long
      MODE_BLCOR_SHORT = 2'd3    // corrected samples, short
   } readout_mode_t;

   typedef enum logic [2:0] {
      FS_IDLE,
      FS_PREAMBLE,
      FS_NWORDS,
      FS_MASK,
      FS_DATA
   } frame_state_t;

   typedef enum logic [2:0] {
      AL_SETTLE,                 // let the link settle
      AL_CHECK,                  // look at bit 3
      AL_SLIP,                   // issue one bitslip
      AL_WAIT,                   // let the slip take effect
      AL_HALT                    // aligned, watch for loss
   } align_state_t;

   typedef struct packed {
      logic    evt_strobe;       // event detected this cycle
      evtime_t evt_time;
      logic    ene_load;         // energy valid this cycle
      energy_t energy;
   } event_in_t;

endpackage

// File: common/dynode_consts.svh
/*
 * dynode readout constants
 * widths, pipeline delays, frame words, FIFO sizing and link alignment timing
 */
`ifndef DYNODE_CONSTS_SVH
`define DYNODE_CONSTS_SVH

`define SAMPLE_W        12       // corrected sample width
`define RAW_W           8        // raw adc width
`define TIME_W          24       // event time width
`define FRAC_W          12       // fractional part of event time
`define WHOLE_W         12       // whole part, zero extended
`define TRIG_W          8        // coincidence trigger byte
`define FIFO_W          16       // fifo word width
`define LINK_W          4        // deserialized trigger link word
`define DLY_W           4        // programmable delay select

`define BLCOR_ALIGN_DLY 15       // fixed delay on corrected samples
`define PILEUP_DLY      3        // tap used after head register
`define MAX_DLY         16       // programmable delay depth

`define FRAME_PREAMBLE  16'hA5A5
`define NWORDS_LONG     33       // raw and corrected frames
`define NWORDS_SHORT    17       // corrected-short frame
`define TRIG_IDLE       8'hFF    // no event
`define TRIG_SAT        8'hF8    // time fraction saturated

`define FIFO_DEPTH      64
`define FIFO_AW         6
`define FIFO_NEARLY     56

`define ALIGN_SETTLE    8        // idle cycles before first check
`define ALIGN_WAIT      5        // cycles after a slip before recheck

`endif
